// ==== design/dp_ref_pkg.sv ====
// DisplayPort reference glue package: lane geometry, symbol, APB and PIO types, register map
package dp_ref_pkg;

    // Lane geometry
    localparam int LANES = 4;                       // DP lanes and GT channels
    localparam int SPL   = 4;                       // Symbols per lane per clock
    localparam int LANE_IDX_W = $clog2(LANES);

    // One TX link symbol, 11 bits
    typedef struct packed {
        logic       disp_mode;                      // 0 automatic, 1 forced
        logic       disp_val;                       // 0 negative, 1 positive
        logic       k;                              // K character
        logic [7:0] dat;
    } tx_sym_t;

    // One RX link symbol, 9 bits
    typedef struct packed {
        logic       k;
        logic [7:0] dat;
    } rx_sym_t;

    // Source lane index for every output lane
    typedef logic [LANES-1:0][LANE_IDX_W-1:0] lane_order_t;

    // APB request from the host
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    // APB response back to the host
    typedef struct packed {
        logic        pready;
        logic        pslverr;
        logic [31:0] prdata;
    } apb_rsp_t;

    // Status inputs, gt_clk_lock is bit 0
    typedef struct packed {
        logic       rxpll_lock;
        logic       txpll_lock;
        logic [1:0] gtpll_lock;
        logic       rx_rst_done;
        logic       tx_rst_done;
        logic       vid_clk_lock;
        logic       gt_clk_lock;
    } pio_in_t;

    // Control outputs, clk_sel is bit 0
    typedef struct packed {
        logic [2:0] rx_rate;
        logic [2:0] tx_rate;
        logic [4:0] tx_postcursor;
        logic [3:0] tx_diffctrl;
        logic       rxpll_rst;
        logic       txpll_rst;
        logic       gtrx_rst;
        logic       gttx_rst;
        logic       dprx_rst;
        logic       dptx_rst;
        logic       clk_sel;                        // Reference clock select
    } pio_out_t;

    // Register map
    localparam logic [7:0] ADDR_PIO_IN  = 8'h00;
    localparam logic [7:0] ADDR_PIO_OUT = 8'h04;
    localparam logic [7:0] ADDR_VERSION = 8'h08;

endpackage

// ==== design/reset_gen.sv ====
// Reset generator: stretches the core reset for a fixed count after external release
`timescale 1ns/1ps

module reset_gen
#(
    parameter int RST_CNT_W = 10
)
(
    input  logic clk_por,
    input  logic sys_clk_from_pll,     // External reset, active high
    output logic core_rst
);

    logic [RST_CNT_W-1:0] rst_cnt;

    always_ff @(posedge clk_por or posedge sys_clk_from_pll)
    begin
        if (sys_clk_from_pll)
        begin
            rst_cnt  <= '0;
            core_rst <= 1'b1;
        end
        else
        begin
            // Count until all ones, then release
            if (!(&rst_cnt))
                rst_cnt <= rst_cnt + 1'b1;
            else
                core_rst <= 1'b0;
        end
    end

    // Once released, the core reset stays low until the next external reset
    a_no_rerise: assert property (
        @(posedge clk_por) disable iff (sys_clk_from_pll)
        !core_rst |=> !core_rst
    );

endmodule

// ==== design/pio_regs.sv ====
// PIO register block: APB slave for transceiver status, board control and version word
`timescale 1ns/1ps

module pio_regs
#(
    parameter logic [7:0] VER_MAJOR = 8'd1,
    parameter logic [7:0] VER_MINOR = 8'd0
)
(
    input  logic                    clk_por,
    input  logic                    core_rst,
    input  dp_ref_pkg::apb_req_t    apb_req,
    input  dp_ref_pkg::pio_in_t     pio_stat,
    output dp_ref_pkg::apb_rsp_t    apb_rsp,
    output dp_ref_pkg::pio_out_t    pio_ctl
);

    localparam int CTL_W = $bits(dp_ref_pkg::pio_out_t);

    dp_ref_pkg::pio_in_t    stat_meta;
    dp_ref_pkg::pio_in_t    stat_sync;
    logic                   apb_setup;
    logic                   apb_write;
    logic                   addr_hit;
    logic [31:0]            rd_data;

    assign apb_setup = apb_req.psel & ~apb_req.penable;
    assign apb_write = apb_req.psel & apb_req.penable & apb_req.pwrite;

    // Status bits come from other clock domains
    always_ff @(posedge clk_por or posedge core_rst)
    begin
        if (core_rst)
        begin
            stat_meta <= '0;
            stat_sync <= '0;
        end
        else
        begin
            stat_meta <= pio_stat;
            stat_sync <= stat_meta;
        end
    end

    // Address decode and read mux
    always_comb
    begin
        addr_hit = 1'b1;
        rd_data  = '0;
        case (apb_req.paddr)
            dp_ref_pkg::ADDR_PIO_IN:  rd_data = 32'(stat_sync);
            dp_ref_pkg::ADDR_PIO_OUT: rd_data = 32'(pio_ctl);     // Upper bits read zero
            dp_ref_pkg::ADDR_VERSION: rd_data = {16'h0000, VER_MAJOR, VER_MINOR};
            default:                  addr_hit = 1'b0;
        endcase
    end

    // Control register, updated at the end of the access cycle
    always_ff @(posedge clk_por or posedge core_rst)
    begin
        if (core_rst)
            pio_ctl <= '0;
        else if (apb_write && (apb_req.paddr == dp_ref_pkg::ADDR_PIO_OUT))
            pio_ctl <= apb_req.pwdata[CTL_W-1:0];
    end

    // Response is prepared during setup so the access cycle has no wait state
    always_ff @(posedge clk_por or posedge core_rst)
    begin
        if (core_rst)
            apb_rsp <= '0;
        else if (apb_setup)
        begin
            apb_rsp.pready  <= 1'b1;
            apb_rsp.pslverr <= ~addr_hit;
            apb_rsp.prdata  <= rd_data;                         // Zero on a miss
        end
        else
        begin
            apb_rsp.pready  <= 1'b0;
            apb_rsp.pslverr <= 1'b0;
        end
    end

    // Access phase must follow a setup phase of the same transfer
    a_apb_phase: assert property (
        @(posedge clk_por) disable iff (core_rst)
        apb_req.penable |-> (apb_req.psel && $past(apb_req.psel))
    );

endmodule

// ==== design/lane_map.sv ====
// Lane map: registered crossbar from source lanes to output lanes, one cycle latency
`timescale 1ns/1ps

module lane_map
#(
    parameter type                     sym_t = logic [8:0],
    parameter dp_ref_pkg::lane_order_t ORDER = {2'd3, 2'd2, 2'd1, 2'd0}
)
(
    input  logic                                            clk_por,
    input  logic                                            core_rst,
    input  sym_t [dp_ref_pkg::LANES-1:0][dp_ref_pkg::SPL-1:0] lanes_in,
    output sym_t [dp_ref_pkg::LANES-1:0][dp_ref_pkg::SPL-1:0] lanes_out
);

    // True when every source lane is used exactly once
    function automatic bit order_is_perm(dp_ref_pkg::lane_order_t ord);
        logic [dp_ref_pkg::LANES-1:0] seen;
        seen = '0;
        for (int i = 0; i < dp_ref_pkg::LANES; i++)
            seen[ord[i]] = 1'b1;
        return &seen;
    endfunction

    // Whole lanes move, symbol order inside a lane is kept
    always_ff @(posedge clk_por or posedge core_rst)
    begin
        if (core_rst)
            lanes_out <= '0;
        else
        begin
            for (int i = 0; i < dp_ref_pkg::LANES; i++)
                lanes_out[i] <= lanes_in[ORDER[i]];
        end
    end

    // A duplicated source would drop one lane entirely
    a_order_perm: assert property (
        @(posedge clk_por) disable iff (core_rst)
        order_is_perm(ORDER)
    );

endmodule

// ==== design/heartbeat.sv ====
// Heartbeat: down-counter that toggles the LED once per beat period
`timescale 1ns/1ps

module heartbeat
#(
    parameter int HB_BEAT = 25_000_000
)
(
    input  logic clk_por,
    input  logic core_rst,
    output logic led
);

    localparam int               CNT_W  = $clog2(HB_BEAT + 1);
    localparam logic [CNT_W-1:0] RELOAD = CNT_W'(HB_BEAT - 1);

    logic [CNT_W-1:0] beat_cnt;

    always_ff @(posedge clk_por or posedge core_rst)
    begin
        if (core_rst)
        begin
            beat_cnt <= RELOAD;
            led      <= 1'b0;
        end
        else if (beat_cnt == '0)
        begin
            beat_cnt <= RELOAD;     // One full beat per toggle
            led      <= ~led;
        end
        else
            beat_cnt <= beat_cnt - 1'b1;
    end

endmodule

// ==== design/dp_ref_top.sv ====
// DisplayPort reference glue top: reset, PIO registers, lane maps and heartbeat
`timescale 1ns/1ps

module dp_ref_top
#(
    parameter int                      RST_CNT_W = 10,
    parameter int                      HB_BEAT   = 25_000_000,
    parameter logic [7:0]              VER_MAJOR = 8'd1,
    parameter logic [7:0]              VER_MINOR = 8'd0,
    // GT0 <- DP3, GT1 <- DP1, GT2 <- DP2, GT3 <- DP0
    parameter dp_ref_pkg::lane_order_t TX_ORDER  = {2'd0, 2'd2, 2'd1, 2'd3},
    // DP0 <- GT0, DP1 <- GT2, DP2 <- GT1, DP3 <- GT3
    parameter dp_ref_pkg::lane_order_t RX_ORDER  = {2'd3, 2'd1, 2'd2, 2'd0}
)
(
    // Clock and external reset
    input  logic                    clk_por,
    input  logic                    sys_clk_from_pll,

    // Register bus
    input  dp_ref_pkg::apb_req_t    apb_req,
    output dp_ref_pkg::apb_rsp_t    apb_rsp,

    // Board status and control
    input  dp_ref_pkg::pio_in_t     pio_stat,
    output dp_ref_pkg::pio_out_t    pio_ctl,

    // TX link, DP core side in, GT side out
    input  dp_ref_pkg::tx_sym_t [dp_ref_pkg::LANES-1:0][dp_ref_pkg::SPL-1:0] dptx_lanes,
    output dp_ref_pkg::tx_sym_t [dp_ref_pkg::LANES-1:0][dp_ref_pkg::SPL-1:0] gt_tx_lanes,

    // RX link, GT side in, DP core side out
    input  dp_ref_pkg::rx_sym_t [dp_ref_pkg::LANES-1:0][dp_ref_pkg::SPL-1:0] gt_rx_lanes,
    output dp_ref_pkg::rx_sym_t [dp_ref_pkg::LANES-1:0][dp_ref_pkg::SPL-1:0] dprx_lanes,

    // Misc
    output logic                    led,
    output logic                    core_rst
);

    // Core reset stretch
    reset_gen
    #(
        .RST_CNT_W          (RST_CNT_W)
    )
    u_reset_gen
    (
        .clk_por            (clk_por),
        .sys_clk_from_pll   (sys_clk_from_pll),
        .core_rst           (core_rst)
    );

    // Status, control and version registers
    pio_regs
    #(
        .VER_MAJOR          (VER_MAJOR),
        .VER_MINOR          (VER_MINOR)
    )
    u_pio_regs
    (
        .clk_por            (clk_por),
        .core_rst           (core_rst),
        .apb_req            (apb_req),
        .pio_stat           (pio_stat),
        .apb_rsp            (apb_rsp),
        .pio_ctl            (pio_ctl)
    );

    // DP TX lanes to GT channels
    lane_map
    #(
        .sym_t              (dp_ref_pkg::tx_sym_t),
        .ORDER              (TX_ORDER)
    )
    u_tx_lane_map
    (
        .clk_por            (clk_por),
        .core_rst           (core_rst),
        .lanes_in           (dptx_lanes),
        .lanes_out          (gt_tx_lanes)
    );

    // GT channels to DP RX lanes
    lane_map
    #(
        .sym_t              (dp_ref_pkg::rx_sym_t),
        .ORDER              (RX_ORDER)
    )
    u_rx_lane_map
    (
        .clk_por            (clk_por),
        .core_rst           (core_rst),
        .lanes_in           (gt_rx_lanes),
        .lanes_out          (dprx_lanes)
    );

    // Board alive LED
    heartbeat
    #(
        .HB_BEAT            (HB_BEAT)
    )
    u_heartbeat
    (
        .clk_por            (clk_por),
        .core_rst           (core_rst),
        .led                (led)
    );

endmodule

// ==== include/tb_tasks.svh ====
// Testbench helpers: LFSR stimulus, value check, APB transfers and timed wait loops
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1, one step per bit taken
function automatic logic [31:0] next_rand(input int nbits);
    logic [31:0] value;
    logic        fb;
    value = '0;
    for (int i = 0; i < nbits; i++)
    begin
        fb          = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state  = {lfsr_state[14:0], fb};
        value       = {value[30:0], fb};
    end
    return value;
endfunction

task automatic check_value(input string what, input logic [255:0] expected,
                           input logic [255:0] actual);
    if (expected !== actual)
        stop_with_error($sformatf("Mismatch in %s: expected %0h, actual %0h",
                                  what, expected, actual));
endtask

// Setup cycle, then access cycle, response sampled mid access
task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
                         output dp_ref_pkg::apb_rsp_t rsp);
    @(negedge clk_por);
    apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
    @(negedge clk_por);
    rsp = apb_rsp;
    apb_req.penable = 1'b1;
    @(negedge clk_por);
    apb_req = '0;               // Bus idle again
endtask

task automatic read_reg(input logic [7:0] addr, output dp_ref_pkg::apb_rsp_t rsp);
    @(negedge clk_por);
    apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: 32'h0};
    @(negedge clk_por);
    rsp = apb_rsp;
    apb_req.penable = 1'b1;
    @(negedge clk_por);
    apb_req = '0;
endtask

// Counts falling edges until core_rst drops, lane and control outputs held at zero
task automatic wait_core_release(output int cycles);
    cycles = 0;
    while (core_rst && cycles < RST_TIMEOUT)
    begin
        @(negedge clk_por);
        cycles++;
        if (core_rst)
        begin
            check_value("reset pio_ctl", '0, pio_ctl);
            check_value("reset led", '0, led);
            check_value("reset pready", '0, apb_rsp.pready);
            check_value("reset gt_tx_lanes", '0, gt_tx_lanes);
            check_value("reset dprx_lanes", '0, dprx_lanes);
        end
    end
    if (core_rst)
        stop_with_error("Core reset was never released");
endtask

task automatic wait_led_toggle(output int cycles);
    logic start;
    start  = led;
    cycles = 0;
    while (led == start && cycles < LED_TIMEOUT)
    begin
        @(negedge clk_por);
        cycles++;
    end
    if (led == start)
        stop_with_error("LED stopped toggling");
endtask

`endif

// ==== test/tb_dp_ref_top.sv ====
// Testbench for the DisplayPort reference glue: reset, registers, lane maps and heartbeat
`timescale 1ns/1ps

module tb_dp_ref_top;

    localparam int         HB_BEAT_TB  = 10;
    localparam logic [7:0] VER_MAJ_TB  = 8'h03;
    localparam logic [7:0] VER_MIN_TB  = 8'h07;
    localparam int         CTL_BITS    = 22;
    localparam int         RST_TIMEOUT = 64;
    localparam int         LED_TIMEOUT = 4 * HB_BEAT_TB;
    localparam int         POLL_TRIES  = 8;
    localparam int         STREAM_LEN  = 24;

    // Source lane for each output lane
    localparam int TX_SRC [dp_ref_pkg::LANES] = '{3, 1, 2, 0};
    localparam int RX_SRC [dp_ref_pkg::LANES] = '{0, 2, 1, 3};

    logic                   clk_por;
    logic                   sys_clk_from_pll;
    dp_ref_pkg::apb_req_t   apb_req;
    dp_ref_pkg::apb_rsp_t   apb_rsp;
    dp_ref_pkg::pio_in_t    pio_stat;
    dp_ref_pkg::pio_out_t   pio_ctl;
    dp_ref_pkg::tx_sym_t [dp_ref_pkg::LANES-1:0][dp_ref_pkg::SPL-1:0] dptx_lanes;
    dp_ref_pkg::tx_sym_t [dp_ref_pkg::LANES-1:0][dp_ref_pkg::SPL-1:0] gt_tx_lanes;
    dp_ref_pkg::rx_sym_t [dp_ref_pkg::LANES-1:0][dp_ref_pkg::SPL-1:0] gt_rx_lanes;
    dp_ref_pkg::rx_sym_t [dp_ref_pkg::LANES-1:0][dp_ref_pkg::SPL-1:0] dprx_lanes;
    logic                   led;
    logic                   core_rst;
    logic [15:0]            lfsr_state = 16'd27;

    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1);
    endtask

    `include "tb_tasks.svh"

    dp_ref_top
    #(
        .RST_CNT_W  (4),
        .HB_BEAT    (HB_BEAT_TB),
        .VER_MAJOR  (VER_MAJ_TB),
        .VER_MINOR  (VER_MIN_TB),
        .TX_ORDER   ({2'd0, 2'd2, 2'd1, 2'd3}),
        .RX_ORDER   ({2'd3, 2'd1, 2'd2, 2'd0})
    )
    UUT
    (
        .clk_por            (clk_por),
        .sys_clk_from_pll   (sys_clk_from_pll),
        .apb_req            (apb_req),
        .apb_rsp            (apb_rsp),
        .pio_stat           (pio_stat),
        .pio_ctl            (pio_ctl),
        .dptx_lanes         (dptx_lanes),
        .gt_tx_lanes        (gt_tx_lanes),
        .gt_rx_lanes        (gt_rx_lanes),
        .dprx_lanes         (dprx_lanes),
        .led                (led),
        .core_rst           (core_rst)
    );

    initial
    begin
        clk_por = 1'b0;
        forever #4 clk_por = ~clk_por;     // 125 MHz
    end

    // 2^4 edges of stretch, then the first LED toggle one beat later
    task automatic reset_release();
        int cycles;
        wait_core_release(cycles);
        check_value("reset release cycles", 16, cycles);
        wait_led_toggle(cycles);
        check_value("first led toggle", HB_BEAT_TB, cycles);
    endtask

    task automatic control_register();
        dp_ref_pkg::apb_rsp_t rsp;
        logic [31:0]          wdata;
        for (int n = 0; n < 6; n++)
        begin
            wdata = next_rand(32);
            write_reg(dp_ref_pkg::ADDR_PIO_OUT, wdata, rsp);
            check_value("ctl write pready", 1, rsp.pready);
            check_value("ctl write pslverr", 0, rsp.pslverr);
            check_value("ctl pio_ctl", wdata[CTL_BITS-1:0], pio_ctl);
            read_reg(dp_ref_pkg::ADDR_PIO_OUT, rsp);
            check_value("ctl read pready", 1, rsp.pready);
            check_value("ctl read pslverr", 0, rsp.pslverr);
            check_value("ctl readback", {10'b0, wdata[CTL_BITS-1:0]}, rsp.prdata);
        end
    endtask

    task automatic status_and_version();
        dp_ref_pkg::apb_rsp_t rsp;
        dp_ref_pkg::pio_out_t ctl_before;
        logic [7:0]           stat;
        int                   tries;
        for (int n = 0; n < 3; n++)
        begin
            @(negedge clk_por);
            stat     = next_rand(8);
            pio_stat = stat;
            tries    = 0;
            do
            begin
                read_reg(dp_ref_pkg::ADDR_PIO_IN, rsp);
                tries++;
            end
            while (rsp.prdata !== {24'b0, stat} && tries < POLL_TRIES);
            if (rsp.prdata !== {24'b0, stat})
                stop_with_error("Status register never showed the new pio_stat value");
            check_value("status pslverr", 0, rsp.pslverr);
        end
        read_reg(dp_ref_pkg::ADDR_VERSION, rsp);
        check_value("version word", {16'h0000, VER_MAJ_TB, VER_MIN_TB}, rsp.prdata);
        check_value("version pslverr", 0, rsp.pslverr);
        ctl_before = pio_ctl;
        write_reg(dp_ref_pkg::ADDR_VERSION, next_rand(32), rsp);    // Read only, no error
        check_value("version write pslverr", 0, rsp.pslverr);
        check_value("version write ignored", ctl_before, pio_ctl);
        read_reg(8'h0C, rsp);
        check_value("unmapped read pready", 1, rsp.pready);
        check_value("unmapped read pslverr", 1, rsp.pslverr);
        check_value("unmapped read data", 0, rsp.prdata);
        write_reg(8'h40, next_rand(32), rsp);
        check_value("unmapped write pslverr", 1, rsp.pslverr);
        check_value("unmapped write ignored", ctl_before, pio_ctl);
    endtask

    task automatic tx_lane_map();
        dp_ref_pkg::tx_sym_t [dp_ref_pkg::LANES-1:0][dp_ref_pkg::SPL-1:0] prev;
        dp_ref_pkg::tx_sym_t [dp_ref_pkg::LANES-1:0][dp_ref_pkg::SPL-1:0] expd;
        for (int c = 0; c < STREAM_LEN; c++)
        begin
            @(negedge clk_por);
            if (c > 0)
            begin
                for (int i = 0; i < dp_ref_pkg::LANES; i++)
                    expd[i] = prev[TX_SRC[i]];
                check_value("tx lane map", expd, gt_tx_lanes);
            end
            for (int l = 0; l < dp_ref_pkg::LANES; l++)
                for (int s = 0; s < dp_ref_pkg::SPL; s++)
                    dptx_lanes[l][s] = next_rand(11);
            prev = dptx_lanes;
        end
    endtask

    task automatic rx_lane_map();
        dp_ref_pkg::rx_sym_t [dp_ref_pkg::LANES-1:0][dp_ref_pkg::SPL-1:0] prev;
        dp_ref_pkg::rx_sym_t [dp_ref_pkg::LANES-1:0][dp_ref_pkg::SPL-1:0] expd;
        for (int c = 0; c < STREAM_LEN; c++)
        begin
            @(negedge clk_por);
            if (c > 0)
            begin
                for (int i = 0; i < dp_ref_pkg::LANES; i++)
                    expd[i] = prev[RX_SRC[i]];
                check_value("rx lane map", expd, dprx_lanes);
            end
            for (int l = 0; l < dp_ref_pkg::LANES; l++)
                for (int s = 0; s < dp_ref_pkg::SPL; s++)
                    gt_rx_lanes[l][s] = next_rand(9);
            prev = gt_rx_lanes;
        end
    endtask

    task automatic led_heartbeat();
        int cycles;
        wait_led_toggle(cycles);        // Align to a toggle first
        for (int n = 0; n < 4; n++)
        begin
            wait_led_toggle(cycles);
            check_value("heartbeat period", HB_BEAT_TB, cycles);
        end
    endtask

    initial
    begin
        sys_clk_from_pll = 1'b1;
        apb_req          = '0;
        pio_stat         = '0;
        dptx_lanes       = '1;
        gt_rx_lanes      = '1;
        repeat (4) @(negedge clk_por);
        sys_clk_from_pll = 1'b0;
        reset_release();
        control_register();
        status_and_version();
        tx_lane_map();
        rx_lane_map();
        led_heartbeat();
        $display("sim passed");
        $finish;
    end

endmodule

// ==== dp_ref_top.f ====
+incdir+include
design/dp_ref_pkg.sv
design/reset_gen.sv
design/pio_regs.sv
design/lane_map.sv
design/heartbeat.sv
design/dp_ref_top.sv
test/tb_dp_ref_top.sv
